// File: filelist.f
src/mips_pkg.sv
src/mips_control.sv
src/mips_regfile.sv
src/mips_exec_unit.sv
src/mips_next_pc.sv
src/mips_load_align.sv
src/mips_cpu_harvard.sv
verification/mips_checker.sv
verification/tb_mips_cpu.sv

// File: src/mips_control.sv
// Instruction decoder
`timescale 1ns/1ps
`default_nettype none

module mips_control (
  input  logic [31:0]     instr,
  output mips_pkg::ctrl_t ctrl
);
  import mips_pkg::*;

  opcode_e    opcode;
  funct_e     funct;
  logic [4:0] rt;

  assign opcode = opcode_e'(instr[31:26]);
  assign funct  = funct_e'(instr[5:0]);
  assign rt     = instr[20:16];

  always_comb
  begin
    // Start from a no-op, then switch on what the instruction needs
    ctrl = '0;
    case (opcode)
      OP_SPECIAL:
      begin
        case (funct)
          FN_ADDU: {ctrl.reg_write, ctrl.reg_dst_rd, ctrl.alu_op} = {2'b11, ALU_ADD};
          FN_SUBU: {ctrl.reg_write, ctrl.reg_dst_rd, ctrl.alu_op} = {2'b11, ALU_SUB};
          FN_AND:  {ctrl.reg_write, ctrl.reg_dst_rd, ctrl.alu_op} = {2'b11, ALU_AND};
          FN_OR:   {ctrl.reg_write, ctrl.reg_dst_rd, ctrl.alu_op} = {2'b11, ALU_OR};
          FN_XOR:  {ctrl.reg_write, ctrl.reg_dst_rd, ctrl.alu_op} = {2'b11, ALU_XOR};
          FN_NOR:  {ctrl.reg_write, ctrl.reg_dst_rd, ctrl.alu_op} = {2'b11, ALU_NOR};
          FN_SLT:  {ctrl.reg_write, ctrl.reg_dst_rd, ctrl.alu_op} = {2'b11, ALU_SLT};
          FN_SLTU: {ctrl.reg_write, ctrl.reg_dst_rd, ctrl.alu_op} = {2'b11, ALU_SLTU};
          // Shifts by the shamt field, operand is rt
          FN_SLL:  {ctrl.reg_write, ctrl.reg_dst_rd, ctrl.alu_op} = {2'b11, ALU_SLL};
          FN_SRL:  {ctrl.reg_write, ctrl.reg_dst_rd, ctrl.alu_op} = {2'b11, ALU_SRL};
          FN_SRA:  {ctrl.reg_write, ctrl.reg_dst_rd, ctrl.alu_op} = {2'b11, ALU_SRA};
          FN_JR:   ctrl.jump_reg = 1'b1;
          FN_JALR:
          begin
            // Link goes to rd, normally 31
            ctrl.jump_reg   = 1'b1;
            ctrl.reg_write  = 1'b1;
            ctrl.reg_dst_rd = 1'b1;
            ctrl.wb_sel     = WB_LINK;
          end
          FN_MFHI:
          begin
            ctrl.reg_write   = 1'b1;
            ctrl.reg_dst_rd  = 1'b1;
            ctrl.wb_sel      = WB_HILO;
            ctrl.hilo_sel_hi = 1'b1;
          end
          FN_MFLO:
          begin
            ctrl.reg_write  = 1'b1;
            ctrl.reg_dst_rd = 1'b1;
            ctrl.wb_sel     = WB_HILO;
          end
          FN_MTHI: {ctrl.hi_write, ctrl.alu_op} = {1'b1, ALU_PASS_RS};
          FN_MTLO: {ctrl.lo_write, ctrl.alu_op} = {1'b1, ALU_PASS_RS};
          FN_MULT:
          begin
            ctrl.mult_en     = 1'b1;
            ctrl.mult_signed = 1'b1;
            ctrl.hi_write    = 1'b1;
            ctrl.lo_write    = 1'b1;
          end
          FN_MULTU: {ctrl.mult_en, ctrl.hi_write, ctrl.lo_write} = 3'b111;
          default: ctrl = '0;
        endcase
      end
      // Only bltz and bgez in the regimm class
      OP_REGIMM:
      begin
        if (rt == 5'd0)
          ctrl.branch = BR_LTZ;
        else if (rt == 5'd1)
          ctrl.branch = BR_GEZ;
      end
      OP_J:    ctrl.jump = 1'b1;
      OP_JAL:  {ctrl.jump, ctrl.reg_write, ctrl.link_ra, ctrl.wb_sel} = {3'b111, WB_LINK};
      OP_BEQ:  ctrl.branch = BR_EQ;
      OP_BNE:  ctrl.branch = BR_NE;
      OP_BLEZ: ctrl.branch = BR_LEZ;
      OP_BGTZ: ctrl.branch = BR_GTZ;
      OP_ADDIU: {ctrl.reg_write, ctrl.alu_src_imm, ctrl.alu_op} = {2'b11, ALU_ADD};
      OP_SLTI:  {ctrl.reg_write, ctrl.alu_src_imm, ctrl.alu_op} = {2'b11, ALU_SLT};
      OP_SLTIU: {ctrl.reg_write, ctrl.alu_src_imm, ctrl.alu_op} = {2'b11, ALU_SLTU};
      OP_LUI:   {ctrl.reg_write, ctrl.alu_src_imm, ctrl.alu_op} = {2'b11, ALU_LUI};
      // Logical immediates are zero extended
      OP_ANDI: {ctrl.reg_write, ctrl.alu_src_imm, ctrl.imm_zero_ext, ctrl.alu_op} = {3'b111, ALU_AND};
      OP_ORI:  {ctrl.reg_write, ctrl.alu_src_imm, ctrl.imm_zero_ext, ctrl.alu_op} = {3'b111, ALU_OR};
      OP_XORI: {ctrl.reg_write, ctrl.alu_src_imm, ctrl.imm_zero_ext, ctrl.alu_op} = {3'b111, ALU_XOR};
      OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU:
      begin
        // Address is rs plus signed offset
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = ALU_ADD;
        ctrl.mem_read    = 1'b1;
        ctrl.wb_sel      = WB_LOAD;
        case (opcode)
          OP_LB:   ctrl.load_kind = LD_BYTE_S;
          OP_LBU:  ctrl.load_kind = LD_BYTE_U;
          OP_LH:   ctrl.load_kind = LD_HALF_S;
          OP_LHU:  ctrl.load_kind = LD_HALF_U;
          default: ctrl.load_kind = LD_WORD;
        endcase
      end
      OP_SW: {ctrl.mem_write, ctrl.alu_src_imm, ctrl.alu_op} = {2'b11, ALU_ADD};
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/mips_cpu_harvard.sv
// Single-cycle MIPS32 subset core
// Harvard memory ports
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_harvard #(
  parameter logic [31:0] RESET_VECTOR = mips_pkg::RESET_VECTOR
) (
  input  logic        clk,
  input  logic        reset,
  output logic        active,
  output logic [31:0] register_v0,
  input  logic        clk_enable,
  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,
  output logic [31:0] data_address,
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata
);
  import mips_pkg::*;

  ctrl_t       ctrl;
  logic        step;
  logic [4:0]  rs_addr;
  logic [4:0]  rt_addr;
  logic [4:0]  rd_addr;
  logic [4:0]  shamt;
  logic [15:0] imm;
  logic [25:0] target_index;
  logic [4:0]  wr_addr;
  logic [31:0] wr_data;
  logic [31:0] rs_data;
  logic [31:0] rt_data;
  logic [31:0] alu_result;
  logic        branch_taken;
  logic [31:0] hilo_value;
  logic [31:0] load_value;
  logic [31:0] pc_plus8;

  // Instruction fields
  assign rs_addr      = instr_readdata[25:21];
  assign rt_addr      = instr_readdata[20:16];
  assign rd_addr      = instr_readdata[15:11];
  assign shamt        = instr_readdata[10:6];
  assign imm          = instr_readdata[15:0];
  assign target_index = instr_readdata[25:0];

  // State moves only when enabled and not yet halted
  assign step = clk_enable & active;

  mips_control u_control (
    .instr (instr_readdata),
    .ctrl  (ctrl)
  );

  // jal links to 31, register forms to rd, the rest to rt
  assign wr_addr = ctrl.link_ra    ? 5'd31 :
                   ctrl.reg_dst_rd ? rd_addr : rt_addr;

  always_comb
  begin
    case (ctrl.wb_sel)
      WB_LOAD: wr_data = load_value;
      WB_LINK: wr_data = pc_plus8;
      WB_HILO: wr_data = hilo_value;
      default: wr_data = alu_result;
    endcase
  end

  mips_regfile u_regfile (
    .clk     (clk),
    .reset   (reset),
    .enable  (step),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .wr_addr (wr_addr),
    .wr_en   (ctrl.reg_write),
    .wr_data (wr_data),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .v0      (register_v0)
  );

  mips_exec_unit u_exec_unit (
    .clk          (clk),
    .reset        (reset),
    .enable       (step),
    .ctrl         (ctrl),
    .rs_data      (rs_data),
    .rt_data      (rt_data),
    .imm          (imm),
    .shamt        (shamt),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .hilo_value   (hilo_value)
  );

  mips_next_pc #(
    .RESET_VECTOR (RESET_VECTOR)
  ) u_next_pc (
    .clk          (clk),
    .reset        (reset),
    .enable       (step),
    .ctrl         (ctrl),
    .branch_taken (branch_taken),
    .rs_data      (rs_data),
    .imm          (imm),
    .target_index (target_index),
    .pc           (instr_address),
    .pc_plus8     (pc_plus8),
    .active       (active)
  );

  // Load address low bits pick the lane
  mips_load_align u_load_align (
    .word        (data_readdata),
    .byte_offset (alu_result[1:0]),
    .kind        (ctrl.load_kind),
    .value       (load_value)
  );

  // Data port, store only signalled on an enabled cycle
  assign data_address   = alu_result;
  assign data_read      = ctrl.mem_read;
  assign data_write     = ctrl.mem_write & step;
  assign data_writedata = rt_data;

endmodule

`default_nettype wire

// File: src/mips_exec_unit.sv
// ALU, branch compare and multiplier
`timescale 1ns/1ps
`default_nettype none

module mips_exec_unit (
  input  logic            clk,
  input  logic            reset,
  input  logic            enable,
  input  mips_pkg::ctrl_t ctrl,
  input  logic [31:0]     rs_data,
  input  logic [31:0]     rt_data,
  input  logic [15:0]     imm,
  input  logic [4:0]      shamt,
  output logic [31:0]     alu_result,
  output logic            branch_taken,
  output logic [31:0]     hilo_value
);
  import mips_pkg::*;

  logic [31:0]        imm_ext;
  logic [31:0]        op_b;
  logic signed [63:0] product_s;
  logic [63:0]        product_u;
  logic [63:0]        product;
  logic [31:0]        hi;
  logic [31:0]        lo;

  // Second operand
  assign imm_ext = ctrl.imm_zero_ext ? {16'd0, imm} : {{16{imm[15]}}, imm};
  assign op_b    = ctrl.alu_src_imm ? imm_ext : rt_data;

  always_comb
  begin
    case (ctrl.alu_op)
      ALU_ADD:     alu_result = rs_data + op_b;
      ALU_SUB:     alu_result = rs_data - op_b;
      ALU_AND:     alu_result = rs_data & op_b;
      ALU_OR:      alu_result = rs_data | op_b;
      ALU_XOR:     alu_result = rs_data ^ op_b;
      ALU_NOR:     alu_result = ~(rs_data | op_b);
      ALU_SLT:     alu_result = {31'd0, $signed(rs_data) < $signed(op_b)};
      ALU_SLTU:    alu_result = {31'd0, rs_data < op_b};
      // Shifts take rt through op_b
      ALU_SLL:     alu_result = op_b << shamt;
      ALU_SRL:     alu_result = op_b >> shamt;
      ALU_SRA:     alu_result = $signed(op_b) >>> shamt;
      ALU_LUI:     alu_result = {imm, 16'd0};
      ALU_PASS_RS: alu_result = rs_data;
      default:     alu_result = 32'd0;
    endcase
  end

  // Branch condition, zero tests on rs only
  always_comb
  begin
    case (ctrl.branch)
      BR_EQ:   branch_taken = (rs_data == rt_data);
      BR_NE:   branch_taken = (rs_data != rt_data);
      BR_LEZ:  branch_taken = rs_data[31] || (rs_data == 32'd0);
      BR_GTZ:  branch_taken = !rs_data[31] && (rs_data != 32'd0);
      BR_LTZ:  branch_taken = rs_data[31];
      BR_GEZ:  branch_taken = !rs_data[31];
      default: branch_taken = 1'b0;
    endcase
  end

  // Kept apart so signedness does not leak between the two forms
  assign product_s = $signed(rs_data) * $signed(rt_data);
  assign product_u = {32'd0, rs_data} * {32'd0, rt_data};
  assign product   = ctrl.mult_signed ? product_s : product_u;

  // HI/LO take the product, or rs for mthi/mtlo
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hi <= 32'd0;
      lo <= 32'd0;
    end
    else if (enable)
    begin
      if (ctrl.hi_write)
        hi <= ctrl.mult_en ? product[63:32] : rs_data;
      if (ctrl.lo_write)
        lo <= ctrl.mult_en ? product[31:0] : rs_data;
    end
  end

  assign hilo_value = ctrl.hilo_sel_hi ? hi : lo;

endmodule

`default_nettype wire

// File: src/mips_load_align.sv
// Sub-word load extraction
`timescale 1ns/1ps
`default_nettype none

module mips_load_align (
  input  logic [31:0]     word,
  input  logic [1:0]      byte_offset,
  input  mips_pkg::load_e kind,
  output logic [31:0]     value
);
  import mips_pkg::*;

  logic [7:0]  lane_byte;
  logic [15:0] lane_half;

  // Big-endian lanes, offset 0 is the top byte
  always_comb
  begin
    case (byte_offset)
      2'd0:    lane_byte = word[31:24];
      2'd1:    lane_byte = word[23:16];
      2'd2:    lane_byte = word[15:8];
      default: lane_byte = word[7:0];
    endcase
  end

  assign lane_half = byte_offset[1] ? word[15:0] : word[31:16];

  always_comb
  begin
    case (kind)
      LD_BYTE_S: value = {{24{lane_byte[7]}}, lane_byte};
      LD_BYTE_U: value = {24'd0, lane_byte};
      LD_HALF_S: value = {{16{lane_half[15]}}, lane_half};
      LD_HALF_U: value = {16'd0, lane_half};
      default:   value = word;
    endcase
  end

endmodule

`default_nettype wire

// File: src/mips_next_pc.sv
// Program counter with delay-slot redirect
`timescale 1ns/1ps
`default_nettype none

module mips_next_pc #(
  parameter logic [31:0] RESET_VECTOR = mips_pkg::RESET_VECTOR
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            enable,
  input  mips_pkg::ctrl_t ctrl,
  input  logic            branch_taken,
  input  logic [31:0]     rs_data,
  input  logic [15:0]     imm,
  input  logic [25:0]     target_index,
  output logic [31:0]     pc,
  output logic [31:0]     pc_plus8,
  output logic            active
);

  logic [31:0] pc_plus4;
  logic [31:0] branch_target;
  logic [31:0] jump_target;
  logic [31:0] target;
  logic        transfer;
  logic        redirect_pending;
  logic [31:0] redirect_target;
  logic [31:0] next_pc;

  assign pc_plus4 = pc + 32'd4;
  assign pc_plus8 = pc + 32'd8;

  // Branch offset is in words, relative to the delay slot
  assign branch_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
  // Jump stays in the 256 MB region of the delay slot
  assign jump_target   = {pc_plus4[31:28], target_index, 2'b00};

  assign target = ctrl.jump_reg ? rs_data :
                  ctrl.jump     ? jump_target : branch_target;

  assign transfer = ctrl.jump | ctrl.jump_reg | branch_taken;

  // Delay slot runs first, the target one cycle later
  assign next_pc = redirect_pending ? redirect_target : pc_plus4;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc               <= RESET_VECTOR;
      redirect_pending <= 1'b0;
      active           <= 1'b1;
    end
    else if (enable)
    begin
      pc               <= next_pc;
      redirect_pending <= transfer;
      // Fetch from address 0 means halt
      if (pc == 32'd0)
        active <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (enable)
      redirect_target <= target;
  end

endmodule

`default_nettype wire

// File: src/mips_pkg.sv
// MIPS32 subset shared definitions
`default_nettype none

package mips_pkg;

  // Boot address of the program
  localparam logic [31:0] RESET_VECTOR = 32'hBFC00000;

  // Major opcodes, bits 31:26
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_REGIMM  = 6'h01,
    OP_J       = 6'h02,
    OP_JAL     = 6'h03,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_BLEZ    = 6'h06,
    OP_BGTZ    = 6'h07,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0A,
    OP_SLTIU   = 6'h0B,
    OP_ANDI    = 6'h0C,
    OP_ORI     = 6'h0D,
    OP_XORI    = 6'h0E,
    OP_LUI     = 6'h0F,
    OP_LB      = 6'h20,
    OP_LH      = 6'h21,
    OP_LW      = 6'h23,
    OP_LBU     = 6'h24,
    OP_LHU     = 6'h25,
    OP_SW      = 6'h2B
  } opcode_e;

  // Function field of the special class, bits 5:0
  typedef enum logic [5:0] {
    FN_SLL   = 6'h00,
    FN_SRL   = 6'h02,
    FN_SRA   = 6'h03,
    FN_JR    = 6'h08,
    FN_JALR  = 6'h09,
    FN_MFHI  = 6'h10,
    FN_MTHI  = 6'h11,
    FN_MFLO  = 6'h12,
    FN_MTLO  = 6'h13,
    FN_MULT  = 6'h18,
    FN_MULTU = 6'h19,
    FN_ADDU  = 6'h21,
    FN_SUBU  = 6'h23,
    FN_AND   = 6'h24,
    FN_OR    = 6'h25,
    FN_XOR   = 6'h26,
    FN_NOR   = 6'h27,
    FN_SLT   = 6'h2A,
    FN_SLTU  = 6'h2B
  } funct_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
    ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_PASS_RS
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
  } branch_e;

  // Write-back source
  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_LINK, WB_HILO} wb_sel_e;

  typedef enum logic [2:0] {
    LD_WORD, LD_BYTE_S, LD_BYTE_U, LD_HALF_S, LD_HALF_U
  } load_e;

  // Decoded control word; all zero is a no-op
  typedef struct packed {
    logic    reg_write;
    logic    reg_dst_rd;
    logic    link_ra;
    alu_op_e alu_op;
    logic    alu_src_imm;
    logic    imm_zero_ext;
    branch_e branch;
    logic    jump;
    logic    jump_reg;
    logic    mem_read;
    logic    mem_write;
    wb_sel_e wb_sel;
    load_e   load_kind;
    logic    mult_signed;
    logic    mult_en;
    logic    hi_write;
    logic    lo_write;
    logic    hilo_sel_hi;
  } ctrl_t;

endpackage

`default_nettype wire

// File: src/mips_regfile.sv
// General purpose register file
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
  input  logic        clk,
  input  logic        reset,
  input  logic        enable,
  input  logic [4:0]  rs_addr,
  input  logic [4:0]  rt_addr,
  input  logic [4:0]  wr_addr,
  input  logic        wr_en,
  input  logic [31:0] wr_data,
  output logic [31:0] rs_data,
  output logic [31:0] rt_data,
  output logic [31:0] v0
);

  logic [31:0] regs [32];

  // Combinational reads
  assign rs_data = regs[rs_addr];
  assign rt_data = regs[rt_addr];

  // Register 2 for the external debug port
  assign v0 = regs[2];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 32; i++)
      begin
        regs[i] <= 32'd0;
      end
    end
    // Register 0 never leaves zero
    else if (enable && wr_en && (wr_addr != 5'd0))
    begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// File: verification/mips_checker.sv
// Store, load, v0 and halt checker
`timescale 1ns/1ps
`default_nettype none

module mips_checker (
  input logic        clk,
  input logic        reset,
  input logic        clk_enable,
  input logic        active,
  input logic        data_write,
  input logic        data_read,
  input logic [31:0] data_address,
  input logic [31:0] data_writedata,
  input logic [31:0] register_v0
);

  string       test_name;
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_load [$];
  logic [31:0] exp_v0;
  int          store_index;
  int          load_index;
  bit          v0_checked;
  int          error_count = 0;

  // Arm a new test with the interpreter's final v0
  function void begin_test(string name, logic [31:0] v0);
    test_name   = name;
    exp_v0      = v0;
    store_index = 0;
    load_index  = 0;
    v0_checked  = 1'b0;
    exp_addr.delete();
    exp_data.delete();
    exp_load.delete();
  endfunction

  function void expect_store(logic [31:0] addr, logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endfunction

  function void expect_load(logic [31:0] addr);
    exp_load.push_back(addr);
  endfunction

  function void report_failure(string what);
    error_count++;
    $display("error in %s: %s", test_name, what);
  endfunction

  function void end_test();
    if (!v0_checked)
      report_failure("halt was never observed");
    if (exp_addr.size() != 0)
      report_failure($sformatf("%0d expected stores never happened", exp_addr.size()));
    if (exp_load.size() != 0)
      report_failure($sformatf("%0d expected loads never happened", exp_load.size()));
  endfunction

  // Stores only count on enabled edges
  always @(posedge clk)
  begin
    if (!reset && data_write)
    begin
      if (!clk_enable)
        report_failure("store signalled while clk_enable was low");
      else if (!active)
        report_failure("store signalled after the halt");
      else if (exp_addr.size() == 0)
        report_failure($sformatf("unexpected store to %h", data_address));
      else
      begin
        if (data_address !== exp_addr[0])
        begin
          error_count++;
          $display("mismatch %s store %0d address expected %h actual %h",
                   test_name, store_index, exp_addr[0], data_address);
        end
        if (data_writedata !== exp_data[0])
        begin
          error_count++;
          $display("mismatch %s store %0d data expected %h actual %h",
                   test_name, store_index, exp_data[0], data_writedata);
        end
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
        store_index++;
      end
    end
  end

  // Load strobe and address on enabled edges before the halt
  always @(posedge clk)
  begin
    if (!reset && clk_enable && active && data_read)
    begin
      if (exp_load.size() == 0)
        report_failure($sformatf("unexpected load from %h", data_address));
      else
      begin
        if (data_address !== exp_load[0])
        begin
          error_count++;
          $display("mismatch %s load %0d address expected %h actual %h",
                   test_name, load_index, exp_load[0], data_address);
        end
        void'(exp_load.pop_front());
        load_index++;
      end
    end
  end

  // First stable point after active falls
  always @(negedge clk)
  begin
    if (!reset && !active && !v0_checked)
    begin
      v0_checked = 1'b1;
      if (register_v0 !== exp_v0)
      begin
        error_count++;
        $display("mismatch %s v0 expected %h actual %h", test_name, exp_v0, register_v0);
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_mips_cpu.sv
// MIPS core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_mips_cpu;
  import mips_pkg::*;

  logic        clk;
  logic        reset;
  logic        clk_enable;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] instr_address;
  logic [31:0] instr_readdata;
  logic [31:0] data_address;
  logic        data_write;
  logic        data_read;
  logic [31:0] data_writedata;
  logic [31:0] data_readdata;

  logic [31:0] rom [128];
  logic [31:0] rom_index;
  logic [31:0] dram [256];
  logic [31:0] ref_mem [256];
  int          prog_len;
  integer      seed;
  bit          timed_out;

  mips_cpu_harvard #(.RESET_VECTOR(RESET_VECTOR)) u_mips_cpu_harvard (
    .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
    .clk_enable(clk_enable), .instr_address(instr_address),
    .instr_readdata(instr_readdata), .data_address(data_address),
    .data_write(data_write), .data_read(data_read),
    .data_writedata(data_writedata), .data_readdata(data_readdata)
  );

  mips_checker u_checker (
    .clk(clk), .reset(reset), .clk_enable(clk_enable), .active(active),
    .data_write(data_write), .data_read(data_read), .data_address(data_address),
    .data_writedata(data_writedata), .register_v0(register_v0)
  );

  always #10 clk = ~clk;

  // Zero outside the image so address 0 reads a nop
  function automatic logic [31:0] instr_read(logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - RESET_VECTOR) >> 2;
    if (addr[1:0] == 2'd0 && idx < 128)
      return rom[idx];
    return 32'd0;
  endfunction

  // Instruction ROM port of the DUT
  assign rom_index      = (instr_address - RESET_VECTOR) >> 2;
  assign instr_readdata = (instr_address[1:0] == 2'd0 && rom_index < 128) ?
                          rom[rom_index] : 32'd0;
  assign data_readdata  = dram[data_address[9:2]];

  always @(posedge clk)
  begin
    if (data_write && clk_enable)
      dram[data_address[9:2]] <= data_writedata;
  end

  function automatic logic [31:0] enc_r(int rs, int rt, int rd, int sh, logic [5:0] fn);
    return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
  endfunction

  function automatic logic [31:0] enc_i(logic [5:0] op, int rs, int rt, logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  function automatic logic [31:0] cur_addr();
    return RESET_VECTOR + 4 * prog_len;
  endfunction

  function automatic void emit(logic [31:0] instr);
    rom[prog_len] = instr;
    prog_len++;
  endfunction

  // Delay slot shifts v0 and the skipped slot adds one
  function automatic void emit_transfer(logic [31:0] instr);
    emit(instr);
    emit(enc_r(0, 2, 2, 1, 6'h00));
    emit(enc_i(6'h09, 2, 2, 16'd1));
  endfunction

  function automatic void build_alu();
    emit(enc_i(6'h0f, 0, 8, 16'h1234));
    emit(enc_i(6'h0d, 8, 8, 16'h5678));
    emit(enc_i(6'h09, 0, 9, 16'hfffb));
    emit(enc_r(8, 9, 10, 0, 6'h21));
    emit(enc_r(10, 9, 11, 0, 6'h23));
    emit(enc_r(8, 9, 12, 0, 6'h24));
    emit(enc_r(12, 9, 13, 0, 6'h25));
    emit(enc_r(13, 8, 14, 0, 6'h26));
    emit(enc_r(9, 8, 15, 0, 6'h2a));
    emit(enc_r(9, 8, 16, 0, 6'h2b));
    emit(enc_r(0, 8, 17, 4, 6'h00));
    emit(enc_r(0, 9, 18, 3, 6'h02));
    emit(enc_r(0, 9, 19, 2, 6'h03));
    emit(enc_i(6'h0a, 9, 20, 16'hfffd));
    emit(enc_i(6'h0c, 9, 21, 16'hff0f));
    emit(enc_i(6'h0e, 8, 22, 16'hffff));
    emit(enc_i(6'h0b, 9, 23, 16'h0010));
    // Fold every result into v0
    for (int k = 10; k <= 23; k++)
    begin
      emit(enc_r(2, k, 2, 0, (k % 2) ? 6'h26 : 6'h21));
      emit(enc_r(0, 2, 2, 1, 6'h00));
    end
  endfunction

  function automatic void build_loads();
    int k;
    k = 0;
    emit(enc_i(6'h09, 0, 8, 16'h0100));
    emit(enc_i(6'h09, 0, 10, 16'h0200));
    for (int w = 0; w < 2; w++)
    begin
      for (int off = 0; off < 4; off++)
      begin
        emit(enc_i(6'h20, 8, 9, 16'(w * 4 + off)));
        emit(enc_i(6'h2b, 10, 9, 16'(4 * k)));
        k++;
        emit(enc_i(6'h24, 8, 9, 16'(w * 4 + off)));
        emit(enc_i(6'h2b, 10, 9, 16'(4 * k)));
        k++;
      end
      for (int off = 0; off < 4; off += 2)
      begin
        emit(enc_i(6'h21, 8, 9, 16'(w * 4 + off)));
        emit(enc_i(6'h2b, 10, 9, 16'(4 * k)));
        k++;
        emit(enc_i(6'h25, 8, 9, 16'(w * 4 + off)));
        emit(enc_i(6'h2b, 10, 9, 16'(4 * k)));
        k++;
      end
      emit(enc_i(6'h23, 8, 9, 16'(w * 4)));
      emit(enc_i(6'h2b, 10, 9, 16'(4 * k)));
      k++;
    end
    emit(enc_r(9, 0, 2, 0, 6'h21));
  endfunction

  function automatic void build_branches();
    logic [31:0] t;
    emit(enc_i(6'h09, 0, 8, 16'd5));
    emit(enc_i(6'h09, 0, 9, 16'hfffd));
    emit(enc_i(6'h09, 0, 10, 16'd5));
    // Taken then untaken per condition with the offset past one slot
    emit_transfer(enc_i(6'h04, 8, 10, 16'd2));
    emit_transfer(enc_i(6'h04, 8, 9, 16'd2));
    emit_transfer(enc_i(6'h05, 8, 9, 16'd2));
    emit_transfer(enc_i(6'h05, 8, 10, 16'd2));
    emit_transfer(enc_i(6'h06, 9, 0, 16'd2));
    emit_transfer(enc_i(6'h06, 8, 0, 16'd2));
    emit_transfer(enc_i(6'h07, 8, 0, 16'd2));
    emit_transfer(enc_i(6'h07, 9, 0, 16'd2));
    emit_transfer(enc_i(6'h01, 9, 0, 16'd2));
    emit_transfer(enc_i(6'h01, 8, 0, 16'd2));
    emit_transfer(enc_i(6'h01, 0, 1, 16'd2));
    emit_transfer(enc_i(6'h01, 9, 1, 16'd2));
    t = cur_addr() + 12;
    emit_transfer({6'h02, t[27:2]});
    t = cur_addr() + 12;
    emit_transfer({6'h03, t[27:2]});
    emit(enc_i(6'h2b, 0, 31, 16'h0300));
    t = cur_addr() + 20;
    emit(enc_i(6'h0f, 0, 11, t[31:16]));
    emit(enc_i(6'h0d, 11, 11, t[15:0]));
    emit_transfer(enc_r(11, 0, 12, 0, 6'h09));
    emit(enc_i(6'h2b, 0, 12, 16'h0304));
    t = cur_addr() + 20;
    emit(enc_i(6'h0f, 0, 13, t[31:16]));
    emit(enc_i(6'h0d, 13, 13, t[15:0]));
    emit_transfer(enc_r(13, 0, 0, 0, 6'h08));
    emit(enc_i(6'h2b, 0, 2, 16'h0308));
  endfunction

  function automatic void build_mult();
    emit(enc_i(6'h0f, 0, 8, 16'h89ab));
    emit(enc_i(6'h0d, 8, 8, 16'hcdef));
    emit(enc_i(6'h09, 0, 9, 16'hfff9));
    emit(enc_r(8, 9, 0, 0, 6'h18));
    emit(enc_r(0, 0, 10, 0, 6'h10));
    emit(enc_r(0, 0, 11, 0, 6'h12));
    emit(enc_r(8, 9, 0, 0, 6'h19));
    emit(enc_r(0, 0, 12, 0, 6'h10));
    emit(enc_r(0, 0, 13, 0, 6'h12));
    emit(enc_r(9, 0, 0, 0, 6'h11));
    emit(enc_r(8, 0, 0, 0, 6'h13));
    emit(enc_r(0, 0, 14, 0, 6'h10));
    emit(enc_r(0, 0, 15, 0, 6'h12));
    for (int k = 10; k <= 15; k++)
      emit(enc_i(6'h2b, 0, k, 16'(16'h0100 + 4 * (k - 10))));
    emit(enc_r(10, 13, 2, 0, 6'h21));
  endfunction

  // Instruction-level model of the subset with one delay slot
  function automatic logic [31:0] run_reference();
    logic [31:0] r [32];
    logic [31:0] hi, lo, pc, npc, tgt, ins, a, b, se, ea, w, val;
    logic [63:0] p;
    logic [5:0]  op, fn;
    logic [4:0]  rt, rd, sh, d;
    bit          pend, we, take;
    int          steps;
    for (int i = 0; i < 32; i++)
      r[i] = 32'd0;
    hi = 0;
    lo = 0;
    pc = RESET_VECTOR;
    pend = 1'b0;
    tgt = 0;
    steps = 0;
    while (pc != 32'd0 && steps < 4000)
    begin
      ins = instr_read(pc);
      op = ins[31:26];
      fn = ins[5:0];
      rt = ins[20:16];
      rd = ins[15:11];
      sh = ins[10:6];
      a = r[ins[25:21]];
      b = r[rt];
      se = {{16{ins[15]}}, ins[15:0]};
      ea = a + se;
      w = ref_mem[ea[9:2]];
      npc = pend ? tgt : pc + 4;
      pend = 1'b0;
      we = 1'b1;
      d = rt;
      val = 0;
      take = 1'b0;
      case (op)
        6'h00:
        begin
          d = rd;
          case (fn)
            6'h00: val = b << sh;
            6'h02: val = b >> sh;
            6'h03: val = $signed(b) >>> sh;
            6'h08: we = 1'b0;
            6'h09: val = pc + 32'd8;
            6'h10: val = hi;
            6'h12: val = lo;
            6'h11: {hi, we} = {a, 1'b0};
            6'h13: {lo, we} = {a, 1'b0};
            6'h18:
            begin
              // Full 64-bit two's complement product
              p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
              {hi, lo, we} = {p, 1'b0};
            end
            6'h19:
            begin
              p = {32'd0, a} * {32'd0, b};
              {hi, lo, we} = {p, 1'b0};
            end
            6'h21: val = a + b;
            6'h23: val = a - b;
            6'h24: val = a & b;
            6'h25: val = a | b;
            6'h26: val = a ^ b;
            6'h27: val = ~(a | b);
            6'h2a: val = ($signed(a) < $signed(b)) ? 1 : 0;
            6'h2b: val = (a < b) ? 1 : 0;
            default: we = 1'b0;
          endcase
          if (fn == 6'h08 || fn == 6'h09)
            {pend, tgt} = {1'b1, a};
        end
        6'h02, 6'h03:
        begin
          {pend, tgt} = {1'b1, (pc + 32'd4) & 32'hf000_0000 | {4'd0, ins[25:0], 2'b00}};
          {we, d, val} = {op[0], 5'd31, pc + 32'd8};
        end
        6'h01, 6'h04, 6'h05, 6'h06, 6'h07:
        begin
          we = 1'b0;
          case (op)
            6'h01: take = (rt == 0) ? a[31] : (rt == 1) ? !a[31] : 1'b0;
            6'h04: take = (a == b);
            6'h05: take = (a != b);
            6'h06: take = ($signed(a) <= 0);
            default: take = ($signed(a) > 0);
          endcase
          if (take)
            {pend, tgt} = {1'b1, pc + 32'd4 + (se << 2)};
        end
        6'h09: val = a + se;
        6'h0a: val = ($signed(a) < $signed(se)) ? 1 : 0;
        6'h0b: val = (a < se) ? 1 : 0;
        6'h0c: val = a & {16'd0, ins[15:0]};
        6'h0d: val = a | {16'd0, ins[15:0]};
        6'h0e: val = a ^ {16'd0, ins[15:0]};
        6'h0f: val = {ins[15:0], 16'd0};
        6'h20: val = {{24{w[31 - 8 * ea[1:0]]}}, 8'(w >> (8 * (3 - ea[1:0])))};
        6'h24: val = {24'd0, 8'(w >> (8 * (3 - ea[1:0])))};
        6'h21: val = ea[1] ? {{16{w[15]}}, w[15:0]} : {{16{w[31]}}, w[31:16]};
        6'h25: val = ea[1] ? {16'd0, w[15:0]} : {16'd0, w[31:16]};
        6'h23: val = w;
        6'h2b:
        begin
          we = 1'b0;
          u_checker.expect_store(ea, b);
          ref_mem[ea[9:2]] = b;
        end
        default: we = 1'b0;
      endcase
      // Every load reads the data port once
      if (op == 6'h20 || op == 6'h21 || op == 6'h23 || op == 6'h24 || op == 6'h25)
        u_checker.expect_load(ea);
      if (we && d != 0)
        r[d] = val;
      pc = npc;
      steps++;
    end
    return r[2];
  endfunction

  task automatic run_test(string name, int prog, bit random_enable);
    int cycles;
    @(posedge clk);
    #1;
    reset = 1'b1;
    clk_enable = 1'b1;
    prog_len = 0;
    for (int i = 0; i < 128; i++)
      rom[i] = 32'd0;
    case (prog)
      1: build_alu();
      2: build_loads();
      3: build_branches();
      default: build_mult();
    endcase
    // Return to address 0 ends the program
    emit(enc_r(0, 0, 0, 0, 6'h08));
    emit(32'd0);
    for (int i = 0; i < 256; i++)
    begin
      dram[i] = {8'(i) ^ 8'ha5, ~8'(i), 8'(i * 37), 8'h80 ^ 8'(i * 3)};
      ref_mem[i] = dram[i];
    end
    u_checker.begin_test(name, 32'd0);
    u_checker.exp_v0 = run_reference();
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    if (active !== 1'b1)
      u_checker.report_failure("active not high after reset");
    cycles = 0;
    while (active && cycles < 2000)
    begin
      @(posedge clk);
      #1;
      clk_enable = random_enable ? (($random(seed) & 3) != 0) : 1'b1;
      cycles++;
    end
    if (active)
    begin
      $display("error in %s: the processor never halted", name);
      timed_out = 1'b1;
    end
    else
    begin
      // Watch a few more edges for stray stores
      repeat (5) @(posedge clk);
      u_checker.end_test();
    end
  endtask

  initial
  begin
    clk = 1'b0;
    reset = 1'b1;
    clk_enable = 1'b1;
    seed = 32'hc782;
    timed_out = 1'b0;
    run_test("alu", 1, 1'b0);
    if (!timed_out)
      run_test("loads", 2, 1'b0);
    if (!timed_out)
      run_test("branches", 3, 1'b0);
    if (!timed_out)
      run_test("mult", 4, 1'b0);
    if (!timed_out)
      run_test("branches_stalled", 3, 1'b1);
    $display("errors: %0d timeouts: %0d", u_checker.error_count, timed_out);
    if (u_checker.error_count == 0 && !timed_out)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire
